// ==== source/net_stack_settings.svh ====
/*
 * network stack settings
 * stream width, station base addresses and
 * the limits used by the traffic statistics
 */
`ifndef NET_STACK_SETTINGS_SVH
`define NET_STACK_SETTINGS_SVH

`define NET_DATA_WIDTH       64

// base addresses are stored lsb first
`define NET_MAC_ADDRESS      48'hE59D_0235_0A00
`define NET_IPV6_ADDRESS     128'hE59D_02FF_FF35_0A02_0000_0000_0000_80FE
`define NET_IP_SUBNET_MASK   32'h00FF_FFFF
`define NET_IP_RESET_ADDRESS 32'hD1D4_010B  // held while in reset
`define NET_GATEWAY_HOST     8'h01          // gateway is host .1

`define NET_STAT_WIDTH       32
`define NET_STALL_LIMIT      2    // tolerated stalled rx cycles

`endif

// ==== source/net_stack_pkg.sv ====
/*
 * network stack types
 * vector types for stream words and station addresses,
 * and the state encoding of the tx merger FSM
 */
`default_nettype none

`include "net_stack_settings.svh"

package net_stack_pkg;

   // stream payload
   typedef logic [`NET_DATA_WIDTH-1:0]   data_t;
   typedef logic [`NET_DATA_WIDTH/8-1:0] keep_t;  // one enable per byte

   // station addresses, lsb first
   typedef logic [47:0]  mac_addr_t;
   typedef logic [31:0]  ip4_addr_t;
   typedef logic [127:0] ip6_addr_t;
   typedef logic [7:0]   board_num_t;

   // statistics
   typedef logic [`NET_STAT_WIDTH-1:0] stat_cnt_t;
   typedef logic [7:0]                 stall_cnt_t;

   typedef enum logic [1:0] {
      MERGE_IDLE,  // no packet in flight
      MERGE_ARP,   // locked on arp source
      MERGE_IP     // locked on ip source
   } merge_state_t;

endpackage

`default_nettype wire

// ==== source/net_addr_config.sv ====
/*
 * station address configuration
 * registers the ip control word (byte swapped) and the board number,
 * then derives mac, ipv6, mask and gateway in a second register stage
 */
`timescale 1ns/10ps
`default_nettype none

`include "net_stack_settings.svh"

module net_addr_config (
   input  wire                        user_clk,
   input  wire                        net_aresetn,
   input  wire net_stack_pkg::ip4_addr_t  set_ip_addr_data,
   input  wire net_stack_pkg::board_num_t set_board_number_data,
   output net_stack_pkg::mac_addr_t   mac_address,
   output net_stack_pkg::ip4_addr_t   ip_address,
   output net_stack_pkg::ip4_addr_t   ip_subnet_mask,
   output net_stack_pkg::ip4_addr_t   ip_default_gateway,
   output net_stack_pkg::ip6_addr_t   link_local_ipv6_address
);
   import net_stack_pkg::*;

   localparam mac_addr_t MAC_BASE  = `NET_MAC_ADDRESS;
   localparam ip6_addr_t IPV6_BASE = `NET_IPV6_ADDRESS;

   ip4_addr_t  local_ip_address;  // first stage
   board_num_t board_number;

   // input stage, valid strobe is tied high so sample every cycle
   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         local_ip_address <= `NET_IP_RESET_ADDRESS;
         board_number     <= '0;
      end else begin
         local_ip_address <= {set_ip_addr_data[7:0],     // control word is big endian
                              set_ip_addr_data[15:8],
                              set_ip_addr_data[23:16],
                              set_ip_addr_data[31:24]};
         board_number     <= set_board_number_data;
      end
   end

   // distribution stage
   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         mac_address             <= '0;
         ip_address              <= '0;
         ip_subnet_mask          <= '0;
         ip_default_gateway      <= '0;
         link_local_ipv6_address <= '0;
      end else begin
         // top octet + board number, wraps at 256
         mac_address             <= {MAC_BASE[47:40] + board_number, MAC_BASE[39:0]};
         link_local_ipv6_address <= {IPV6_BASE[127:120] + board_number, IPV6_BASE[119:0]};
         ip_address              <= local_ip_address;  // static branch only
         ip_subnet_mask          <= `NET_IP_SUBNET_MASK;
         // last octet sits in 31:24 (lsb first)
         ip_default_gateway      <= {`NET_GATEWAY_HOST, local_ip_address[23:0]};
      end
   end

endmodule

`default_nettype wire

// ==== source/rx_reg_slice.sv ====
/*
 * rx register slice
 * two entry skid buffer between the network rx stream and the ip handler,
 * full throughput with a registered ready towards the network
 */
`timescale 1ns/10ps
`default_nettype none

module rx_reg_slice (
   input  wire                       user_clk,
   input  wire                       net_aresetn,
   input  wire                       rx_valid,
   output logic                      rx_ready,
   input  wire net_stack_pkg::data_t rx_data,
   input  wire net_stack_pkg::keep_t rx_keep,
   input  wire                       rx_last,
   output logic                      rx_out_valid,
   input  wire                       rx_out_ready,
   output net_stack_pkg::data_t      rx_out_data,
   output net_stack_pkg::keep_t      rx_out_keep,
   output logic                      rx_out_last
);
   import net_stack_pkg::*;

   logic  skid_valid;
   data_t skid_data;  // holds the beat caught while ready was still high
   keep_t skid_keep;
   logic  skid_last;

   logic in_fire;
   logic load_main;   // main register free this cycle
   logic skid_valid_d;

   assign in_fire      = rx_valid & rx_ready;
   assign load_main    = ~rx_out_valid | rx_out_ready;
   assign skid_valid_d = skid_valid ? ~load_main : (in_fire & ~load_main);

   // control
   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         rx_out_valid <= 1'b0;
         skid_valid   <= 1'b0;
         rx_ready     <= 1'b1;
      end else begin
         if (load_main)
            rx_out_valid <= skid_valid | in_fire;
         skid_valid <= skid_valid_d;
         rx_ready   <= ~skid_valid_d;  // low once both entries hold a beat
      end
   end

   // payload
   always_ff @(posedge user_clk) begin
      if (load_main) begin
         if (skid_valid) begin  // skid drains first, keeps order
            rx_out_data <= skid_data;
            rx_out_keep <= skid_keep;
            rx_out_last <= skid_last;
         end else if (in_fire) begin
            rx_out_data <= rx_data;
            rx_out_keep <= rx_keep;
            rx_out_last <= rx_last;
         end
      end else if (in_fire) begin  // main stalled, park in skid
         skid_data <= rx_data;
         skid_keep <= rx_keep;
         skid_last <= rx_last;
      end
   end

endmodule

`default_nettype wire

// ==== source/tx_packet_merger.sv ====
/*
 * tx packet merger
 * merges the arp and ip tx streams into the network tx stream,
 * round robin at packet granularity, zero latency
 */
`timescale 1ns/10ps
`default_nettype none

module tx_packet_merger (
   input  wire                       user_clk,
   input  wire                       net_aresetn,
   input  wire                       arp_tx_valid,
   output logic                      arp_tx_ready,
   input  wire net_stack_pkg::data_t arp_tx_data,
   input  wire net_stack_pkg::keep_t arp_tx_keep,
   input  wire                       arp_tx_last,
   input  wire                       ip_tx_valid,
   output logic                      ip_tx_ready,
   input  wire net_stack_pkg::data_t ip_tx_data,
   input  wire net_stack_pkg::keep_t ip_tx_keep,
   input  wire                       ip_tx_last,
   output logic                      net_tx_valid,
   input  wire                       net_tx_ready,
   output net_stack_pkg::data_t      net_tx_data,
   output net_stack_pkg::keep_t      net_tx_keep,
   output logic                      net_tx_last
);
   import net_stack_pkg::*;

   merge_state_t state;
   logic         last_ip;  // ip packet was served last
   logic         sel_arp;
   logic         sel_ip;
   logic         out_fire;

   // grant, fixed while locked
   always_comb begin
      sel_arp = 1'b0;
      sel_ip  = 1'b0;
      case (state)
         MERGE_ARP: sel_arp = 1'b1;
         MERGE_IP:  sel_ip  = 1'b1;
         default: begin
            if (arp_tx_valid && ip_tx_valid) begin
               sel_arp = last_ip;  // both waiting, other one's turn
               sel_ip  = ~last_ip;
            end else begin
               sel_arp = arp_tx_valid;
               sel_ip  = ip_tx_valid;
            end
         end
      endcase
   end

   // output mux
   assign net_tx_valid = (sel_arp & arp_tx_valid) | (sel_ip & ip_tx_valid);
   assign net_tx_data  = sel_arp ? arp_tx_data : ip_tx_data;
   assign net_tx_keep  = sel_arp ? arp_tx_keep : ip_tx_keep;
   assign net_tx_last  = sel_arp ? arp_tx_last : ip_tx_last;

   assign arp_tx_ready = sel_arp & net_tx_ready;  // loser sees ready low
   assign ip_tx_ready  = sel_ip & net_tx_ready;
   assign out_fire     = net_tx_valid & net_tx_ready;

   // lock as soon as a beat is offered so the output holds under back-pressure
   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         state   <= MERGE_IDLE;
         last_ip <= 1'b1;  // arp wins the first tie
      end else begin
         if (out_fire && net_tx_last) begin
            state   <= MERGE_IDLE;  // release on last beat
            last_ip <= sel_ip;
         end else if (net_tx_valid) begin
            state <= sel_arp ? MERGE_ARP : MERGE_IP;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/net_traffic_stats.sv ====
/*
 * traffic statistics
 * rx and tx word / packet counters plus a sticky flag
 * for a receive stream that stays stalled too long
 */
`timescale 1ns/10ps
`default_nettype none

`include "net_stack_settings.svh"

module net_traffic_stats (
   input  wire                      user_clk,
   input  wire                      net_aresetn,
   input  wire                      rx_valid,
   input  wire                      rx_ready,
   input  wire                      rx_last,
   input  wire                      net_tx_valid,
   input  wire                      net_tx_ready,
   input  wire                      net_tx_last,
   output net_stack_pkg::stat_cnt_t rx_word_count,
   output net_stack_pkg::stat_cnt_t rx_pkg_count,
   output net_stack_pkg::stat_cnt_t tx_word_count,
   output net_stack_pkg::stat_cnt_t tx_pkg_count,
   output logic                     rx_stream_down
);
   import net_stack_pkg::*;

   stall_cnt_t stall_count;  // consecutive stalled rx cycles
   logic       rx_fire;
   logic       tx_fire;

   assign rx_fire = rx_valid & rx_ready;
   assign tx_fire = net_tx_valid & net_tx_ready;

   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         rx_word_count  <= '0;
         rx_pkg_count   <= '0;
         tx_word_count  <= '0;
         tx_pkg_count   <= '0;
         stall_count    <= '0;
         rx_stream_down <= 1'b0;
      end else begin
         if (rx_fire) begin
            rx_word_count <= rx_word_count + 1'b1;
            if (rx_last)
               rx_pkg_count <= rx_pkg_count + 1'b1;
         end
         if (tx_fire) begin
            tx_word_count <= tx_word_count + 1'b1;
            if (net_tx_last)
               tx_pkg_count <= tx_pkg_count + 1'b1;
         end

         if (rx_ready)
            stall_count <= '0;
         else if (rx_valid && stall_count != '1)  // saturate
            stall_count <= stall_count + 1'b1;

         if (stall_count > `NET_STALL_LIMIT)
            rx_stream_down <= 1'b1;  // sticky until reset
      end
   end

endmodule

`default_nettype wire

// ==== source/net_stack_core.sv ====
/*
 * network stack core
 * top level of the stack glue: address config, rx slice,
 * tx arp/ip merger and traffic statistics
 */
`timescale 1ns/10ps
`default_nettype none

module net_stack_core (
   input  wire                            user_clk,
   input  wire                            net_aresetn,
   input  wire net_stack_pkg::ip4_addr_t  set_ip_addr_data,
   input  wire net_stack_pkg::board_num_t set_board_number_data,
   // network rx
   input  wire                            rx_valid,
   output logic                           rx_ready,
   input  wire net_stack_pkg::data_t      rx_data,
   input  wire net_stack_pkg::keep_t      rx_keep,
   input  wire                            rx_last,
   // towards ip handler
   output logic                           rx_out_valid,
   input  wire                            rx_out_ready,
   output net_stack_pkg::data_t           rx_out_data,
   output net_stack_pkg::keep_t           rx_out_keep,
   output logic                           rx_out_last,
   // tx sources
   input  wire                            arp_tx_valid,
   output logic                           arp_tx_ready,
   input  wire net_stack_pkg::data_t      arp_tx_data,
   input  wire net_stack_pkg::keep_t      arp_tx_keep,
   input  wire                            arp_tx_last,
   input  wire                            ip_tx_valid,
   output logic                           ip_tx_ready,
   input  wire net_stack_pkg::data_t      ip_tx_data,
   input  wire net_stack_pkg::keep_t      ip_tx_keep,
   input  wire                            ip_tx_last,
   // network tx
   output logic                           net_tx_valid,
   input  wire                            net_tx_ready,
   output net_stack_pkg::data_t           net_tx_data,
   output net_stack_pkg::keep_t           net_tx_keep,
   output logic                           net_tx_last,
   // station addresses
   output net_stack_pkg::mac_addr_t       mac_address,
   output net_stack_pkg::ip4_addr_t       ip_address,
   output net_stack_pkg::ip4_addr_t       ip_subnet_mask,
   output net_stack_pkg::ip4_addr_t       ip_default_gateway,
   output net_stack_pkg::ip6_addr_t       link_local_ipv6_address,
   // statistics
   output net_stack_pkg::stat_cnt_t       rx_word_count,
   output net_stack_pkg::stat_cnt_t       rx_pkg_count,
   output net_stack_pkg::stat_cnt_t       tx_word_count,
   output net_stack_pkg::stat_cnt_t       tx_pkg_count,
   output logic                           rx_stream_down
);

   net_addr_config net_addr_config_i (
      .user_clk, .net_aresetn,
      .set_ip_addr_data, .set_board_number_data,
      .mac_address, .ip_address, .ip_subnet_mask,
      .ip_default_gateway, .link_local_ipv6_address
   );

   rx_reg_slice rx_reg_slice_i (
      .user_clk, .net_aresetn,
      .rx_valid, .rx_ready, .rx_data, .rx_keep, .rx_last,
      .rx_out_valid, .rx_out_ready, .rx_out_data, .rx_out_keep, .rx_out_last
   );

   tx_packet_merger tx_packet_merger_i (
      .user_clk, .net_aresetn,
      .arp_tx_valid, .arp_tx_ready, .arp_tx_data, .arp_tx_keep, .arp_tx_last,
      .ip_tx_valid, .ip_tx_ready, .ip_tx_data, .ip_tx_keep, .ip_tx_last,
      .net_tx_valid, .net_tx_ready, .net_tx_data, .net_tx_keep, .net_tx_last
   );

   // watches rx at the slice input and the merged tx stream
   net_traffic_stats net_traffic_stats_i (
      .user_clk, .net_aresetn,
      .rx_valid, .rx_ready, .rx_last,
      .net_tx_valid, .net_tx_ready, .net_tx_last,
      .rx_word_count, .rx_pkg_count, .tx_word_count, .tx_pkg_count,
      .rx_stream_down
   );

endmodule

`default_nettype wire

// ==== sim/net_stack_chk.sv ====
/*
 * network stack protocol checker
 * stream stability, packet lock of the tx merger,
 * sticky stall flag and tx state after reset
 */
`timescale 1ns/10ps
`default_nettype none

module net_stack_chk (
   input wire                       user_clk,
   input wire                       net_aresetn,
   input wire                       rx_out_valid,
   input wire                       rx_out_ready,
   input wire net_stack_pkg::data_t rx_out_data,
   input wire net_stack_pkg::keep_t rx_out_keep,
   input wire                       rx_out_last,
   input wire                       arp_tx_ready,
   input wire                       ip_tx_ready,
   input wire                       net_tx_valid,
   input wire                       net_tx_ready,
   input wire net_stack_pkg::data_t net_tx_data,
   input wire net_stack_pkg::keep_t net_tx_keep,
   input wire                       net_tx_last,
   input wire                       rx_stream_down
);
   int   fail_count = 0;  // read by the testbench
   logic arp_locked;      // arp packet in flight
   logic ip_locked;

   always_ff @(posedge user_clk) begin
      if (!net_aresetn) begin
         arp_locked <= 1'b0;
         ip_locked  <= 1'b0;
      end else if (net_tx_valid && net_tx_ready) begin
         arp_locked <= arp_tx_ready & ~net_tx_last;
         ip_locked  <= ip_tx_ready & ~net_tx_last;
      end
   end

   rx_out_hold: assert property (@(posedge user_clk) disable iff (!net_aresetn)
      rx_out_valid && !rx_out_ready |=> rx_out_valid && $stable(rx_out_data)
         && $stable(rx_out_keep) && $stable(rx_out_last))
      else begin
         $error("rx_out changed under back-pressure");
         fail_count++;
      end

   net_tx_hold: assert property (@(posedge user_clk) disable iff (!net_aresetn)
      net_tx_valid && !net_tx_ready |=> net_tx_valid && $stable(net_tx_data)
         && $stable(net_tx_keep) && $stable(net_tx_last))
      else begin
         $error("net_tx changed under back-pressure");
         fail_count++;
      end

   arp_lock: assert property (@(posedge user_clk) disable iff (!net_aresetn)
      arp_locked |-> !ip_tx_ready)
      else begin
         $error("ip granted inside arp packet");
         fail_count++;
      end

   ip_lock: assert property (@(posedge user_clk) disable iff (!net_aresetn)
      ip_locked |-> !arp_tx_ready)
      else begin
         $error("arp granted inside ip packet");
         fail_count++;
      end

   down_sticky: assert property (@(posedge user_clk) disable iff (!net_aresetn)
      $past(rx_stream_down) |-> rx_stream_down)
      else begin
         $error("rx_stream_down fell");
         fail_count++;
      end

   // no source granted yet, so neither valid nor ready passes
   tx_idle_after_reset: assert property (@(posedge user_clk)
      $rose(net_aresetn) |-> !net_tx_valid && !arp_tx_ready && !ip_tx_ready)
      else begin
         $error("net_tx not idle after reset");
         fail_count++;
      end

endmodule

bind net_stack_core net_stack_chk net_stack_chk_i (.*);

`default_nettype wire

// ==== sim/net_stack_tb.sv ====
/*
 * network stack testbench
 * address config, rx slice scoreboard, tx merger scoreboard,
 * statistics and the sticky stall flag
 */
`timescale 1ns/10ps
`default_nettype none

`include "net_stack_settings.svh"

module net_stack_tb;
   import net_stack_pkg::*;

   localparam int BW      = `NET_DATA_WIDTH + `NET_DATA_WIDTH/8 + 1;
   localparam int TIMEOUT = 200;  // cycles per wait
   typedef logic [BW-1:0] beat_t; // {last, keep, data}

   logic user_clk, net_aresetn;
   ip4_addr_t set_ip_addr_data;
   board_num_t set_board_number_data;
   logic rx_valid, rx_ready, rx_last, rx_out_valid, rx_out_ready, rx_out_last;
   data_t rx_data, rx_out_data;
   keep_t rx_keep, rx_out_keep;
   logic arp_tx_valid, arp_tx_ready, arp_tx_last, ip_tx_valid, ip_tx_ready, ip_tx_last;
   data_t arp_tx_data, ip_tx_data, net_tx_data;
   keep_t arp_tx_keep, ip_tx_keep, net_tx_keep;
   logic net_tx_valid, net_tx_ready, net_tx_last;
   mac_addr_t mac_address;
   ip4_addr_t ip_address, ip_subnet_mask, ip_default_gateway;
   ip6_addr_t link_local_ipv6_address;
   stat_cnt_t rx_word_count, rx_pkg_count, tx_word_count, tx_pkg_count;
   logic rx_stream_down;

   int errors = 0, tests = 0, failed_tests = 0, hangs = 0;
   int rx_beats = 0, rx_pkts = 0, tx_beats = 0, tx_pkts = 0;
   beat_t rx_q[$], arp_q[$], ip_q[$];
   logic rx_toggle = 0, tx_toggle = 0;  // random back-pressure enables
   int   low_run = 0;
   logic tx_in_pkt = 0, tx_src_arp = 0;

   net_stack_core net_stack_core_i (.*);

   initial begin
      user_clk = 1'b0;
      forever #2 user_clk = ~user_clk;
   end

   task automatic check(input bit ok, input string msg);
      assert (ok) else begin
         $display("** Error @ %0t ns: %s", $time, msg);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests++;
      if (errors != errs_before) failed_tests++;
      $display("test %s: %s", name, (errors == errs_before) ? "passed" : "failed");
   endtask

   function automatic logic src_ready(input int src);
      case (src)
         0: return rx_ready;
         1: return arp_tx_ready;
         default: return ip_tx_ready;
      endcase
   endfunction

   task automatic set_valid(input int src, input logic v, input beat_t b);
      case (src)
         0: {rx_valid, rx_last, rx_keep, rx_data} = {v, b};
         1: {arp_tx_valid, arp_tx_last, arp_tx_keep, arp_tx_data} = {v, b};
         default: {ip_tx_valid, ip_tx_last, ip_tx_keep, ip_tx_data} = {v, b};
      endcase
   endtask

   // one packet then valid drops only if gap > 0
   task automatic send_packet(input int src, input int beats, input int gap);
      beat_t b;
      int    t;
      for (int i = 0; i < beats; i++) begin
         b = {i == beats - 1, keep_t'($urandom()), $urandom(), $urandom()};
         @(negedge user_clk);
         set_valid(src, 1'b1, b);
         if (src == 1) arp_q.push_back(b);
         if (src == 2) ip_q.push_back(b);
         t = 0;
         do begin
            @(posedge user_clk);
            t++;
         end while (!src_ready(src) && t < TIMEOUT);
         if (t >= TIMEOUT) begin
            $display("timeout: stream %0d never accepted a beat", src);
            hangs++;
         end
      end
      if (gap > 0) begin
         @(negedge user_clk);
         set_valid(src, 1'b0, '0);
         repeat (gap - 1) @(negedge user_clk);
      end
   endtask

   task automatic wait_drained();
      int t;
      t = 0;
      while ((rx_q.size() || arp_q.size() || ip_q.size()) && t < TIMEOUT) begin
         @(posedge user_clk);
         t++;
      end
      if (t >= TIMEOUT) begin
         $display("timeout: scoreboards did not drain");
         hangs++;
      end
   endtask

   // random back-pressure with rx_out low at most two cycles in a row
   always @(negedge user_clk) begin
      if (rx_toggle) begin
         rx_out_ready = (low_run >= 2) ? 1'b1 : 1'($urandom() % 2);
         low_run = rx_out_ready ? 0 : low_run + 1;
      end
      if (tx_toggle) net_tx_ready = 1'($urandom() % 2);
   end

   // rx scoreboard checks that accepted order reappears on rx_out
   always @(posedge user_clk) begin
      if (net_aresetn) begin
         if (rx_valid && rx_ready) begin
            rx_q.push_back({rx_last, rx_keep, rx_data});
            rx_beats++;
            if (rx_last) rx_pkts++;
         end
         if (rx_out_valid && rx_out_ready) begin
            check(rx_q.size() > 0, "rx_out beat with nothing accepted");
            if (rx_q.size() > 0)
               check(rx_q.pop_front() == {rx_out_last, rx_out_keep, rx_out_data},
                     "rx_out beat mismatch");
         end
      end
   end

   // tx scoreboard for per source order plus packet lock and alternation
   always @(posedge user_clk) begin
      if (net_aresetn && net_tx_valid && net_tx_ready) begin
         if (tx_in_pkt)
            check(arp_tx_ready == tx_src_arp, "net_tx switched source inside packet");
         else begin
            if (arp_tx_valid && ip_tx_valid && tx_pkts > 0)
               check(arp_tx_ready != tx_src_arp, "merger did not alternate");
            tx_src_arp = arp_tx_ready;
         end
         if (arp_tx_ready) begin
            check(arp_q.size() > 0 && arp_q.pop_front() ==
                  {net_tx_last, net_tx_keep, net_tx_data}, "arp beat mismatch");
         end else begin
            check(ip_q.size() > 0 && ip_q.pop_front() ==
                  {net_tx_last, net_tx_keep, net_tx_data}, "ip beat mismatch");
         end
         tx_in_pkt = !net_tx_last;
         tx_beats++;
         if (net_tx_last) tx_pkts++;
      end
   end

   initial begin
      int e;
      ip4_addr_t d, exp_ip;
      board_num_t bn;
      mac_addr_t mac_base;
      ip6_addr_t ip6_base;
      void'($urandom(84));
      mac_base = `NET_MAC_ADDRESS;
      ip6_base = `NET_IPV6_ADDRESS;
      net_aresetn = 1'b0;
      set_ip_addr_data = '0;
      set_board_number_data = '0;
      set_valid(0, 1'b0, '0);
      set_valid(1, 1'b0, '0);
      set_valid(2, 1'b0, '0);
      rx_out_ready = 1'b1;
      net_tx_ready = 1'b1;
      repeat (16) @(posedge user_clk);
      @(negedge user_clk);
      net_aresetn = 1'b1;

      e = errors;  // ip address through two register stages
      for (int i = 0; i < 6; i++) begin
         d = $urandom();
         exp_ip = {d[7:0], d[15:8], d[23:16], d[31:24]};
         @(negedge user_clk);
         set_ip_addr_data = d;
         repeat (4) @(negedge user_clk);
         check(ip_address == exp_ip, "ip_address not byte reversed input");
         check(ip_default_gateway == {8'd1, exp_ip[23:0]}, "wrong default gateway");
         check(ip_subnet_mask == `NET_IP_SUBNET_MASK, "wrong subnet mask");
      end
      end_test("ip_config", e);

      e = errors;
      for (int i = 0; i < 6; i++) begin
         bn = board_num_t'($urandom());
         set_board_number_data = bn;
         repeat (4) @(negedge user_clk);
         check(mac_address == {8'(mac_base[47:40] + bn), mac_base[39:0]},
               "mac_address wrong for board number");
         check(link_local_ipv6_address == {8'(ip6_base[127:120] + bn), ip6_base[119:0]},
               "ipv6 address wrong for board number");
      end
      end_test("board_number", e);

      e = errors;
      rx_toggle = 1'b1;
      for (int p = 0; p < 20; p++)
         send_packet(0, 1 + $urandom() % 6, 1 + $urandom() % 3);
      rx_toggle = 1'b0;
      rx_out_ready = 1'b1;
      wait_drained();
      end_test("rx_slice", e);

      e = errors;
      tx_toggle = 1'b1;
      fork
         for (int p = 0; p < 10; p++) send_packet(1, 1 + $urandom() % 4, p == 9);
         for (int p = 0; p < 10; p++) send_packet(2, 1 + $urandom() % 5, p == 9);
      join
      tx_toggle = 1'b0;
      net_tx_ready = 1'b1;
      wait_drained();
      end_test("tx_merger", e);

      e = errors;
      repeat (5) @(negedge user_clk);
      check(rx_word_count == stat_cnt_t'(rx_beats), "rx_word_count wrong");
      check(rx_pkg_count == stat_cnt_t'(rx_pkts), "rx_pkg_count wrong");
      check(tx_word_count == stat_cnt_t'(tx_beats), "tx_word_count wrong");
      check(tx_pkg_count == stat_cnt_t'(tx_pkts), "tx_pkg_count wrong");
      check(!rx_stream_down, "rx_stream_down set by short stalls");
      end_test("statistics", e);

      e = errors;
      rx_out_ready = 1'b0;
      fork
         send_packet(0, 6, 1);
         begin
            repeat (20) @(negedge user_clk);
            check(rx_stream_down, "rx_stream_down not set after long stall");
            rx_out_ready = 1'b1;
         end
      join
      wait_drained();
      repeat (4) @(negedge user_clk);
      check(rx_stream_down, "rx_stream_down cleared after traffic resumed");
      end_test("stall_flag", e);

      $display("tests %0d, failed %0d, errors %0d, timeouts %0d, assertion failures %0d",
               tests, failed_tests, errors, hangs, net_stack_core_i.net_stack_chk_i.fail_count);
      if (errors == 0 && hangs == 0 && net_stack_core_i.net_stack_chk_i.fail_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/net_stack_pkg.sv
source/net_addr_config.sv
source/rx_reg_slice.sv
source/tx_packet_merger.sv
source/net_traffic_stats.sv
source/net_stack_core.sv
sim/net_stack_chk.sv
sim/net_stack_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := net_stack_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
